/* logic/ioproc_pkg.sv */
`default_nettype none

package ioproc_pkg;

    localparam int word_width = 8;
    localparam int port_count = 4;

    // ALU operations, results wrap to one word
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_xor = 2'd2,
        op_and = 2'd3
    } alu_op_e;

    typedef logic [word_width-1:0] word_t;
    typedef logic [port_count-1:0] port_mask_t;

    // --------------------
    // Port buses into and out of the core

    typedef struct packed {
        port_mask_t                   read_ready_a;
        port_mask_t                   read_ready_b;
        port_mask_t                   write_ready_a;
        port_mask_t                   write_ready_b;
        word_t      [port_count-1:0]  read_a;
        word_t      [port_count-1:0]  read_b;
    } port_in_t;

    typedef struct packed {
        word_t      [port_count-1:0]  write_a;
        word_t      [port_count-1:0]  write_b;
        port_mask_t                   rden_a;
        port_mask_t                   rden_b;
        port_mask_t                   wren_a;
        port_mask_t                   wren_b;
    } port_out_t;

endpackage

`default_nettype wire

/* logic/harness_pkg.sv */
`default_nettype none

package harness_pkg;

    // Serial frame lengths in bits
    localparam int in_frame_width  = 82;
    localparam int out_frame_width = 80;

    // --------------------
    // Input frame, opcode shifted in first

    typedef struct packed {
        ioproc_pkg::alu_op_e   op;
        ioproc_pkg::port_in_t  ports;
    } in_frame_t;

    // --------------------
    // Output frame, write words leave first

    typedef struct packed {
        ioproc_pkg::port_out_t ports;
    } out_frame_t;

endpackage

`default_nettype wire

/* logic/harness_input_register.sv */
`timescale 1ns/100ps
`default_nettype none

module harness_input_register (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     in,
    input  wire                     load,
    output harness_pkg::in_frame_t  frame,
    output logic                    frame_valid
);

    logic [harness_pkg::in_frame_width-1:0] chain;
    logic [harness_pkg::in_frame_width-1:0] holding;

    // Serial chain, first bit ends up at the MSB
    always_ff @(posedge clock) begin
        if (!load) begin
            chain <= {chain[harness_pkg::in_frame_width-2:0], in};
        end
    end

    // Holding register keeps the chain stable while the next frame shifts in
    always_ff @(posedge clock) begin
        if (load) begin
            holding <= chain;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= load;
        end
    end

    assign frame = harness_pkg::in_frame_t'(holding);

endmodule

`default_nettype wire

/* logic/harness_output_register.sv */
`timescale 1ns/100ps
`default_nettype none

module harness_output_register (
    input  wire                      clock,
    input  wire                      rst,
    input  wire                      capture,
    input  wire harness_pkg::out_frame_t frame,
    output wire                      out
);

    logic [harness_pkg::out_frame_width-1:0] shift;

    // --------------------
    // Capture or shift

    // A new capture overwrites whatever is still shifting out
    always_ff @(posedge clock) begin
        if (rst) begin
            shift <= '0;
        end else if (capture) begin
            shift <= frame;
        end else begin
            shift <= {shift[harness_pkg::out_frame_width-2:0], 1'b0};
        end
    end

    // MSB first
    assign out = shift[harness_pkg::out_frame_width-1];

endmodule

`default_nettype wire

/* logic/io_port_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module io_port_lane (
    input  wire                      clock,
    input  wire                      rst,
    input  wire                      start,
    input  wire ioproc_pkg::alu_op_e op,
    input  wire                      read_ready_a,
    input  wire                      read_ready_b,
    input  wire                      write_ready_a,
    input  wire                      write_ready_b,
    input  wire ioproc_pkg::word_t   read_a,
    input  wire ioproc_pkg::word_t   read_b,
    output logic                     rden_a,
    output logic                     rden_b,
    output logic                     wren_a,
    output logic                     wren_b,
    output ioproc_pkg::word_t        write_a,
    output ioproc_pkg::word_t        write_b
);

    ioproc_pkg::alu_op_e op_q;
    ioproc_pkg::word_t   a_q;
    ioproc_pkg::word_t   b_q;
    logic                go_q;
    logic                fire;

    function automatic ioproc_pkg::word_t alu(
        input ioproc_pkg::alu_op_e f,
        input ioproc_pkg::word_t   x,
        input ioproc_pkg::word_t   y
    );
        case (f)
            ioproc_pkg::op_add: alu = x + y;
            ioproc_pkg::op_sub: alu = x - y;
            ioproc_pkg::op_xor: alu = x ^ y;
            default:            alu = x & y;
        endcase
    endfunction

    // --------------------
    // Stage one, operands and readiness

    always_ff @(posedge clock) begin
        op_q <= op;
        a_q  <= read_a;
        b_q  <= read_b;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            go_q <= 1'b0;
        end else begin
            go_q <= start & read_ready_a & read_ready_b & write_ready_a & write_ready_b;
        end
    end

    // --------------------
    // Stage two, both ALU directions

    always_ff @(posedge clock) begin
        if (rst) begin
            fire    <= 1'b0;
            write_a <= '0;
            write_b <= '0;
        end else begin
            fire <= go_q;
            // Idle lane keeps its last words
            if (go_q) begin
                write_a <= alu(op_q, a_q, b_q);
                write_b <= alu(op_q, b_q, a_q);
            end
        end
    end

    assign rden_a = fire;
    assign rden_b = fire;
    assign wren_a = fire;
    assign wren_b = fire;

endmodule

`default_nettype wire

/* logic/io_proc_core.sv */
`timescale 1ns/100ps
`default_nettype none

module io_proc_core (
    input  wire                       clock,
    input  wire                       rst,
    input  wire                       frame_valid,
    input  wire ioproc_pkg::alu_op_e  op,
    input  wire ioproc_pkg::port_in_t ports_in,
    output ioproc_pkg::port_out_t     ports_out,
    output logic                      result_valid
);

    ioproc_pkg::word_t [ioproc_pkg::port_count-1:0] write_a;
    ioproc_pkg::word_t [ioproc_pkg::port_count-1:0] write_b;
    ioproc_pkg::port_mask_t                         rden_a;
    ioproc_pkg::port_mask_t                         rden_b;
    ioproc_pkg::port_mask_t                         wren_a;
    ioproc_pkg::port_mask_t                         wren_b;
    logic                                           valid_q;

    // --------------------
    // Port lanes, one shared opcode for all

    for (genvar i = 0; i < ioproc_pkg::port_count; i++) begin : g_lane
        io_port_lane lane_i (
            .clock         (clock),
            .rst           (rst),
            .start         (frame_valid),
            .op            (op),
            .read_ready_a  (ports_in.read_ready_a[i]),
            .read_ready_b  (ports_in.read_ready_b[i]),
            .write_ready_a (ports_in.write_ready_a[i]),
            .write_ready_b (ports_in.write_ready_b[i]),
            .read_a        (ports_in.read_a[i]),
            .read_b        (ports_in.read_b[i]),
            .rden_a        (rden_a[i]),
            .rden_b        (rden_b[i]),
            .wren_a        (wren_a[i]),
            .wren_b        (wren_b[i]),
            .write_a       (write_a[i]),
            .write_b       (write_b[i])
        );
    end

    assign ports_out = '{write_a: write_a, write_b: write_b,
                         rden_a: rden_a, rden_b: rden_b,
                         wren_a: wren_a, wren_b: wren_b};

    // --------------------
    // Valid pipeline, matches the two lane stages

    always_ff @(posedge clock) begin
        if (rst) begin
            valid_q      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            valid_q      <= frame_valid;
            result_valid <= valid_q;
        end
    end

endmodule

`default_nettype wire

/* logic/generic_test_harness.sv */
`timescale 1ns/100ps
`default_nettype none

module generic_test_harness (
    input  wire  clock,
    input  wire  rst,
    input  wire  test_in,
    input  wire  test_load,
    output wire  test_out
);

    harness_pkg::in_frame_t  in_frame;
    harness_pkg::out_frame_t out_frame;
    ioproc_pkg::port_out_t   ports_out;
    logic                    frame_valid;
    logic                    result_valid;

    // --------------------
    // Serial in

    harness_input_register input_i (
        .clock       (clock),
        .rst         (rst),
        .in          (test_in),
        .load        (test_load),
        .frame       (in_frame),
        .frame_valid (frame_valid)
    );

    // --------------------
    // Core

    io_proc_core core_i (
        .clock        (clock),
        .rst          (rst),
        .frame_valid  (frame_valid),
        .op           (in_frame.op),
        .ports_in     (in_frame.ports),
        .ports_out    (ports_out),
        .result_valid (result_valid)
    );

    assign out_frame = '{ports: ports_out};

    // --------------------
    // Serial out

    harness_output_register output_i (
        .clock   (clock),
        .rst     (rst),
        .capture (result_valid),
        .frame   (out_frame),
        .out     (test_out)
    );

endmodule

`default_nettype wire

/* tests/io_proc_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module io_proc_checker (
    input wire                        clock,
    input wire                        rst,
    input wire                        frame_valid,
    input wire ioproc_pkg::port_in_t  ports_in,
    input wire                        result_valid,
    input wire ioproc_pkg::port_out_t ports_out
);

    int                     fail_count = 0;
    ioproc_pkg::port_mask_t go_mask;

    // Ports with both reads holding data and both writes with room
    assign go_mask = ports_in.read_ready_a & ports_in.read_ready_b
                   & ports_in.write_ready_a & ports_in.write_ready_b;

    // --------------------
    // Enable masks

    // All four masks equal, and each port follows its go condition two cycles on
    enables_per_side : assert property (
        @(posedge clock) disable iff (rst)
        (ports_out.rden_a == ports_out.wren_a) && (ports_out.rden_b == ports_out.wren_b)
        && (ports_out.rden_a == ports_out.rden_b)
        && (ports_out.rden_a == ($past(frame_valid, 2) ? $past(go_mask, 2) : '0))
    ) else begin
        fail_count++;
        $error("enable masks differ between sides or from the port go condition");
    end

    enables_idle : assert property (
        @(posedge clock) disable iff (rst)
        !result_valid |-> ((ports_out.rden_a | ports_out.rden_b
                          | ports_out.wren_a | ports_out.wren_b) == '0)
    ) else begin
        fail_count++;
        $error("enables raised without result valid");
    end

    // --------------------
    // Valid timing

    valid_latency : assert property (
        @(posedge clock) disable iff (rst)
        result_valid == $past(frame_valid, 2)
    ) else begin
        fail_count++;
        $error("result valid is not frame valid delayed by two cycles");
    end

endmodule

`default_nettype wire

/* tests/generic_test_harness_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module generic_test_harness_tb;

    localparam int row_count = 12;

    logic clock;
    logic rst;
    logic test_in;
    logic test_load;
    wire  test_out;

    harness_pkg::in_frame_t stim_q[$];
    ioproc_pkg::port_out_t  expected_q[$];
    logic [31:0]            rand_state = 32'h7f26_7b40;
    int                     check_count = 0;
    int                     error_count = 0;

    generic_test_harness dut_i (
        .clock     (clock),
        .rst       (rst),
        .test_in   (test_in),
        .test_load (test_load),
        .test_out  (test_out)
    );

    bind io_proc_core io_proc_checker checker_i (
        .clock        (clock),
        .rst          (rst),
        .frame_valid  (frame_valid),
        .ports_in     (ports_in),
        .result_valid (result_valid),
        .ports_out    (ports_out)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // --------------------
    // Stimulus table

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(
        input ioproc_pkg::alu_op_e    op,
        input ioproc_pkg::port_mask_t rra,
        input ioproc_pkg::port_mask_t rrb,
        input ioproc_pkg::port_mask_t wra,
        input ioproc_pkg::port_mask_t wrb,
        input logic [31:0]            words_a,
        input logic [31:0]            words_b
    );
        harness_pkg::in_frame_t f;
        f.op                  = op;
        f.ports.read_ready_a  = rra;
        f.ports.read_ready_b  = rrb;
        f.ports.write_ready_a = wra;
        f.ports.write_ready_b = wrb;
        f.ports.read_a        = words_a;
        f.ports.read_b        = words_b;
        stim_q.push_back(f);
    endtask

    // Flags ORed from two draws so most ports are ready
    task automatic add_random_row();
        harness_pkg::in_frame_t f;
        rand_state = lcg_next(rand_state);
        f.op = ioproc_pkg::alu_op_e'(rand_state[31:30]);
        f.ports.read_ready_a = rand_state[27:24] | rand_state[23:20];
        f.ports.read_ready_b = rand_state[19:16] | rand_state[15:12];
        rand_state = lcg_next(rand_state);
        f.ports.write_ready_a = rand_state[31:28] | rand_state[27:24];
        f.ports.write_ready_b = rand_state[23:20] | rand_state[19:16];
        rand_state = lcg_next(rand_state);
        f.ports.read_a = rand_state;
        rand_state = lcg_next(rand_state);
        f.ports.read_b = rand_state;
        stim_q.push_back(f);
    endtask

    task automatic build_table();
        // All ports ready, with wraparound words
        add_row(ioproc_pkg::op_add, 4'hf, 4'hf, 4'hf, 4'hf, 32'hf0_7f_01_ff, 32'h20_81_ff_01);
        add_row(ioproc_pkg::op_sub, 4'hf, 4'hf, 4'hf, 4'hf, 32'h05_00_80_10, 32'h10_01_7f_10);
        add_row(ioproc_pkg::op_xor, 4'hf, 4'hf, 4'hf, 4'hf, 32'ha5_3c_0f_ff, 32'h5a_c3_f0_00);
        add_row(ioproc_pkg::op_and, 4'hf, 4'hf, 4'hf, 4'hf, 32'hf0_3c_aa_ff, 32'h0f_ff_55_81);
        // Only port 3 ready
        add_row(ioproc_pkg::op_add, 4'he, 4'hd, 4'hb, 4'hf, 32'h11_22_33_44, 32'h55_66_77_88);
        // Port 3 write B full
        add_row(ioproc_pkg::op_xor, 4'hf, 4'hf, 4'hf, 4'h7, 32'hde_ad_be_ef, 32'h0f_0f_0f_0f);
        // Nothing ready, all words hold
        add_row(ioproc_pkg::op_sub, 4'h0, 4'hf, 4'hf, 4'hf, 32'h01_02_03_04, 32'h05_06_07_08);
        repeat (row_count - 7) add_random_row();
    endtask

    // --------------------
    // Reference model

    function automatic ioproc_pkg::word_t expected_word(
        input ioproc_pkg::alu_op_e op,
        input ioproc_pkg::word_t   x,
        input ioproc_pkg::word_t   y
    );
        int                sum;
        ioproc_pkg::word_t result;
        sum = 0;
        case (op)
            ioproc_pkg::op_add: sum = int'(x) + int'(y);
            ioproc_pkg::op_sub: sum = int'(x) - int'(y) + 256;
            ioproc_pkg::op_xor: sum = int'(x ^ y);
            default:            sum = int'(x & y);
        endcase
        result = ioproc_pkg::word_t'(sum % 256);
        return result;
    endfunction

    // Write words start at zero after reset and carry across rows
    task automatic compute_expected();
        ioproc_pkg::word_t [ioproc_pkg::port_count-1:0] last_a;
        ioproc_pkg::word_t [ioproc_pkg::port_count-1:0] last_b;
        ioproc_pkg::port_mask_t                         go;
        ioproc_pkg::port_out_t                          e;
        harness_pkg::in_frame_t                         s;
        logic [1:0]                                     idx;
        last_a = '0;
        last_b = '0;
        for (int r = 0; r < stim_q.size(); r++) begin
            s  = stim_q[r];
            go = s.ports.read_ready_a & s.ports.read_ready_b
               & s.ports.write_ready_a & s.ports.write_ready_b;
            for (int p = 0; p < ioproc_pkg::port_count; p++) begin
                idx = 2'(p);
                if (go[idx]) begin
                    last_a[idx] = expected_word(s.op, s.ports.read_a[idx], s.ports.read_b[idx]);
                    last_b[idx] = expected_word(s.op, s.ports.read_b[idx], s.ports.read_a[idx]);
                end
            end
            e.write_a = last_a;
            e.write_b = last_b;
            e.rden_a  = go;
            e.rden_b  = go;
            e.wren_a  = go;
            e.wren_b  = go;
            expected_q.push_back(e);
        end
    endtask

    // --------------------
    // Serial access

    task automatic send_frame(input harness_pkg::in_frame_t f);
        logic [harness_pkg::in_frame_width-1:0] bits;
        bits = f;
        repeat (harness_pkg::in_frame_width) begin
            @(negedge clock);
            test_load = 1'b0;
            test_in   = bits[harness_pkg::in_frame_width-1];
            bits      = bits << 1;
        end
        @(negedge clock);
        test_load = 1'b1;
        test_in   = 1'b0;
        // Core latency plus the capture edge
        repeat (3) begin
            @(negedge clock);
            test_load = 1'b0;
        end
    endtask

    task automatic receive_frame(output ioproc_pkg::port_out_t got);
        logic [harness_pkg::out_frame_width-1:0] bits;
        bits = '0;
        repeat (harness_pkg::out_frame_width) begin
            @(negedge clock);
            bits = {bits[harness_pkg::out_frame_width-2:0], test_out};
        end
        got = ioproc_pkg::port_out_t'(bits);
    endtask

    // --------------------
    // Compare tasks

    task automatic check_word(
        input string             name,
        input ioproc_pkg::word_t got,
        input ioproc_pkg::word_t exp
    );
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_mask(
        input string                  name,
        input ioproc_pkg::port_mask_t got,
        input ioproc_pkg::port_mask_t exp
    );
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_frame(
        input string                 tag,
        input ioproc_pkg::port_out_t got,
        input ioproc_pkg::port_out_t exp
    );
        logic [1:0] idx;
        for (int p = 0; p < ioproc_pkg::port_count; p++) begin
            idx = 2'(p);
            check_word($sformatf("%s write_a[%0d]", tag, p), got.write_a[idx], exp.write_a[idx]);
            check_word($sformatf("%s write_b[%0d]", tag, p), got.write_b[idx], exp.write_b[idx]);
        end
        check_mask({tag, " rden_a"}, got.rden_a, exp.rden_a);
        check_mask({tag, " rden_b"}, got.rden_b, exp.rden_b);
        check_mask({tag, " wren_a"}, got.wren_a, exp.wren_a);
        check_mask({tag, " wren_b"}, got.wren_b, exp.wren_b);
    endtask

    // --------------------
    // Main sequence

    initial begin
        ioproc_pkg::port_out_t got;
        rst       = 1'b1;
        test_in   = 1'b0;
        test_load = 1'b0;
        build_table();
        compute_expected();
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        // No load yet, output stays clear
        receive_frame(got);
        compare_frame("reset", got, '0);
        for (int r = 0; r < stim_q.size(); r++) begin
            send_frame(stim_q[r]);
            receive_frame(got);
            compare_frame($sformatf("row %0d", r), got, expected_q[r]);
        end
        error_count += dut_i.core_i.checker_i.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, dut_i.core_i.checker_i.fail_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (row_count * 170 + 100) @(posedge clock);
        $display("watchdog expired before all rows were checked");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
logic/ioproc_pkg.sv
logic/harness_pkg.sv
logic/harness_input_register.sv
logic/harness_output_register.sv
logic/io_port_lane.sv
logic/io_proc_core.sv
logic/generic_test_harness.sv
tests/io_proc_checker.sv
tests/generic_test_harness_tb.sv

/* Makefile */
# Verilator build and run for the serial test harness

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := generic_test_harness_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard logic/*.sv tests/*.sv)
BINARY    := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code is not used
test: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: PASS" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
